//--- list.f
verilog/rv32m_pkg.sv
verilog/mul_partial_products.sv
verilog/multiplier.sv
verilog/multiply_unit.sv
sim/multiply_unit_asserts.sv
sim/tb_multiply_unit.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  -f list.f \
  --top-module tb_multiply_unit \
  -o sim_multiply_unit

# An assertion stop gives a nonzero exit, which the grep below still turns into a failure
./obj_dir/sim_multiply_unit 2>&1 | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
  echo "run.sh: PASS"
  exit 0
else
  echo "run.sh: FAIL"
  exit 1
fi

//--- sim/tb_multiply_unit.sv
// Self-checking testbench for multiply_unit; seeded random funct3 and operands, one operation in flight at a time
`timescale 1ns/1ps

module tb_multiply_unit;
  import rv32m_pkg::*;

  logic              CLK;
  logic              nRST;
  logic              start;
  logic              decode_done;
  m_funct_t          funct3;
  logic [WORD_W-1:0] rs1_data;
  logic [WORD_W-1:0] rs2_data;
  logic              busy;
  logic              done;
  logic [WORD_W-1:0] wdata;

  int seed;
  int errors = 0;
  int checks = 0;
  logic timed_out = 1'b0;  // Set once done never showed, the run then winds down

  // Values that stress the sign and carry paths of the multiplier
  logic [WORD_W-1:0] corners [4] = '{32'h0000_0000, 32'hFFFF_FFFF, 32'h8000_0000, 32'h7FFF_FFFF};

  multiply_unit i_dut (
    .CLK         (CLK),
    .nRST        (nRST),
    .start       (start),
    .decode_done (decode_done),
    .funct3      (funct3),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .busy        (busy),
    .done        (done),
    .wdata       (wdata)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;  // 10 ns period
  end

  // Reference product built from the ISA sign rules with plain 64-bit signed arithmetic
  function automatic logic [WORD_W-1:0] model_result(input m_funct_t f,
                                                     input logic [WORD_W-1:0] a,
                                                     input logic [WORD_W-1:0] b);
    logic signed [PROD_W-1:0] a_ext;
    logic signed [PROD_W-1:0] b_ext;
    logic signed [PROD_W-1:0] prod;
    a_ext = {{WORD_W{a[WORD_W-1]}}, a};  // Sign extension unless the rule says unsigned
    b_ext = {{WORD_W{b[WORD_W-1]}}, b};
    if (f == FUNCT_MULHU) begin
      a_ext = {{WORD_W{1'b0}}, a};
      b_ext = {{WORD_W{1'b0}}, b};
    end else if (f == FUNCT_MULHSU) begin
      b_ext = {{WORD_W{1'b0}}, b};  // rs1 keeps its sign, rs2 is unsigned
    end
    prod = a_ext * b_ext;  // Modulo 2^64 still gives the right bits for MULHU
    if (f == FUNCT_MUL) begin
      return prod[WORD_W-1:0];
    end
    return prod[PROD_W-1:WORD_W];
  endfunction

  task automatic check_word(input string name, input logic [WORD_W-1:0] expected,
                            input logic [WORD_W-1:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] t=%0t %s: expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] t=%0t %s: expected %b, got %b", $time, name, expected, actual);
    end
  endtask

  // Counts edges from the issue edge until done shows up while busy must stay high
  task automatic wait_for_done(output int cycles);
    cycles = 0;
    do begin
      @(posedge CLK);
      #1;
      cycles++;
      if (!done) begin
        check_bit("busy", 1'b1, busy);
      end
    end while (!done && cycles < 20);
    if (!done) begin
      errors++;
      timed_out = 1'b1;
      $display("Timeout: done did not rise within 20 cycles after start at t=%0t", $time);
    end
  endtask

  // Draws an operand, about one in four is a corner value
  task automatic pick_operand(output logic [WORD_W-1:0] v);
    logic [31:0] r;
    r = $random(seed);
    if (r[3:2] == 2'b00) begin
      v = corners[r[1:0]];
    end else begin
      v = $random(seed);
    end
  endtask

  // One full core transaction; hold keeps start high that many cycles after done
  task automatic run_op(input m_funct_t f, input logic [WORD_W-1:0] a,
                        input logic [WORD_W-1:0] b, input int hold);
    int                cycles;
    logic [WORD_W-1:0] expected;
    if (timed_out) begin
      return;
    end
    expected = model_result(f, a, b);
    funct3   = f;
    rs1_data = a;
    rs2_data = b;
    start    = 1'b1;  // The next edge is the issue edge
    wait_for_done(cycles);
    if (timed_out) begin
      return;
    end
    check_word("latency", MUL_LATENCY, cycles);
    check_word("wdata", expected, wdata);
    check_bit("busy", 1'b0, busy);  // busy is start and not done
    repeat (hold) begin
      @(posedge CLK);
      #1;
      check_bit("done", 1'b0, done);  // Pending blocks a second issue while start is held
      check_bit("busy", 1'b1, busy);
    end
    start       = 1'b0;
    decode_done = 1'b1;  // Release pulse from the core
    @(posedge CLK);
    #1;
    check_bit("done", 1'b0, done);  // done lasts a single cycle
    check_bit("busy", 1'b0, busy);
    decode_done = 1'b0;
  endtask

  initial begin
    logic [WORD_W-1:0] a;
    logic [WORD_W-1:0] b;
    logic [31:0]       r;
    m_funct_t          f;
    int                hold;
    seed        = 82;
    nRST        = 1'b0;
    start       = 1'b0;
    decode_done = 1'b0;
    funct3      = FUNCT_MUL;
    rs1_data    = '0;
    rs2_data    = '0;
    repeat (8) @(posedge CLK);
    #1;
    nRST = 1'b1;
    check_bit("busy", 1'b0, busy);
    check_bit("done", 1'b0, done);
    @(posedge CLK);
    #1;

    // Directed corners first, including the most negative value squared
    run_op(FUNCT_MULH, 32'h8000_0000, 32'h8000_0000, 0);
    run_op(FUNCT_MULHU, 32'h8000_0000, 32'h8000_0000, 0);
    run_op(FUNCT_MULHSU, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 0);
    run_op(FUNCT_MULHSU, 32'h8000_0000, 32'h7FFF_FFFF, 0);
    run_op(FUNCT_MULHSU, 32'h0000_0003, 32'hFFFF_FFFF, 0);
    run_op(FUNCT_MUL, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 0);
    run_op(FUNCT_MUL, 32'h7FFF_FFFF, 32'h0000_0000, 0);
    run_op(FUNCT_MULHU, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 5);  // Start held long after done

    for (int i = 0; i < 300; i++) begin
      if (timed_out) begin
        break;
      end
      r = $random(seed);
      f = m_funct_t'({1'b0, r[1:0]});
      hold = (r[4:2] == 3'b000) ? 3 : 0;  // Now and then the core is slow to release
      pick_operand(a);
      pick_operand(b);
      run_op(f, a, b, hold);
      repeat (r[6:5]) begin
        @(posedge CLK);
        #1;
        check_bit("done", 1'b0, done);  // Idle gap with start low
      end
    end

    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- sim/multiply_unit_asserts.sv
// Protocol assertions bound into multiply_unit; they assume a single operation in flight
`timescale 1ns/1ps

module multiply_unit_asserts (
  input logic CLK,
  input logic nRST,
  input logic issue,
  input logic done,
  input logic busy
);
  import rv32m_pkg::*;

  // Every issue edge is answered by done after the full pipeline depth
  a_issue_to_done: assert property (
    @(posedge CLK) disable iff (!nRST)
    issue |-> ##MUL_LATENCY done
  ) else $error("done missing MUL_LATENCY edges after issue");

  // A rising done must trace back to an issue exactly that far back
  a_done_from_issue: assert property (
    @(posedge CLK) disable iff (!nRST)
    $rose(done) |-> $past(issue, MUL_LATENCY)
  ) else $error("done rose without an issue MUL_LATENCY edges earlier");

  a_done_one_cycle: assert property (
    @(posedge CLK) disable iff (!nRST)
    done |=> !done  // Result is shown for one cycle only
  ) else $error("done stayed high for more than one cycle");

  // The busy flag holds from the issue cycle through the pipe and drops as the result shows
  a_busy_until_done: assert property (
    @(posedge CLK) disable iff (!nRST)
    issue |-> busy ##1 busy ##(MUL_LATENCY-2) busy ##1 !busy
  ) else $error("busy did not stay high from issue until done");

endmodule

// Attach the checks to every multiply_unit instance
bind multiply_unit multiply_unit_asserts i_asserts (
  .CLK   (CLK),
  .nRST  (nRST),
  .issue (issue),
  .done  (done),
  .busy  (busy)
);

//--- verilog/multiply_unit.sv
// RV32M multiply unit; one operation at a time, funct3 and operands held until done, result shown for one cycle
`timescale 1ns/1ps

module multiply_unit (
  input  logic                         CLK,
  input  logic                         nRST,
  input  logic                         start,
  input  logic                         decode_done,
  input  rv32m_pkg::m_funct_t          funct3,
  input  logic [rv32m_pkg::WORD_W-1:0] rs1_data,
  input  logic [rv32m_pkg::WORD_W-1:0] rs2_data,
  output logic                         busy,
  output logic                         done,
  output logic [rv32m_pkg::WORD_W-1:0] wdata
);
  import rv32m_pkg::*;

  sign_type_t             op_sign;
  sign_type_t             mul_sign;
  logic                   high_sel;
  logic                   swap_ops;
  logic [WORD_W-1:0]      multiplicand;
  logic [WORD_W-1:0]      multiplier_op;
  logic                   pending;
  logic                   issue;
  logic [MUL_LATENCY-1:0] sel_line;
  logic                   finished;
  logic [PROD_W-1:0]      product;

  // Decode signedness and which half of the product the instruction wants
  always_comb begin
    op_sign  = SIGNED_SIGNED;
    high_sel = 1'b0;
    case (funct3)
      FUNCT_MUL: begin
        op_sign  = SIGNED_SIGNED;  // Low word is the same for any signedness
        high_sel = 1'b0;
      end
      FUNCT_MULH: begin
        op_sign  = SIGNED_SIGNED;
        high_sel = 1'b1;
      end
      FUNCT_MULHSU: begin
        op_sign  = SIGNED_UNSIGNED;
        high_sel = 1'b1;
      end
      FUNCT_MULHU: begin
        op_sign  = UNSIGNED_UNSIGNED;
        high_sel = 1'b1;
      end
      default: begin
        op_sign  = SIGNED_SIGNED;  // Unused codes behave like MUL
        high_sel = 1'b0;
      end
    endcase
  end

  // Signed rs1 by unsigned rs2 is turned around so the multiplier sees unsigned by signed
  assign swap_ops      = (op_sign == SIGNED_UNSIGNED);
  assign multiplicand  = swap_ops ? rs2_data : rs1_data;
  assign multiplier_op = swap_ops ? rs1_data : rs2_data;
  assign mul_sign      = swap_ops ? UNSIGNED_SIGNED : op_sign;

  // Pending stops a held start from issuing again until the core releases the unit
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pending <= 1'b0;
    end else if (decode_done) begin
      pending <= 1'b0;  // Release wins over a new issue
    end else if (issue) begin
      pending <= 1'b1;
    end
  end

  assign issue = start & ~pending;  // High for exactly the issue cycle

  // The select follows the operation down the pipe and relies on funct3 staying put
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      sel_line <= '0;
    end else begin
      sel_line <= {sel_line[MUL_LATENCY-2:0], high_sel};
    end
  end

  // Early finish flag is not needed by this wrapper
  multiplier i_multiplier (
    .CLK           (CLK),
    .nRST          (nRST),
    .multiplicand  (multiplicand),
    .multiplier_op (multiplier_op),
    .is_signed     (mul_sign),
    .start         (issue),
    .finished      (finished),
    .next_finished (),
    .product       (product)
  );

  assign done  = finished;
  assign busy  = start & ~done;  // Low in the done cycle and high again while start is still held
  assign wdata = sel_line[MUL_LATENCY-1] ? product[PROD_W-1:WORD_W] : product[WORD_W-1:0];

endmodule

//--- verilog/multiplier.sv
// Three-stage 33x33 signed multiplier keeping the low 64 product bits; one issue per edge is allowed
`timescale 1ns/1ps

module multiplier (
  input  logic                         CLK,
  input  logic                         nRST,
  input  logic [rv32m_pkg::WORD_W-1:0] multiplicand,
  input  logic [rv32m_pkg::WORD_W-1:0] multiplier_op,
  input  rv32m_pkg::sign_type_t        is_signed,
  input  logic                         start,
  output logic                         finished,
  output logic                         next_finished,
  output logic [rv32m_pkg::PROD_W-1:0] product
);
  import rv32m_pkg::*;

  logic                    s1_valid;
  logic [EXT_W-1:0]        pp_ll;
  logic signed [EXT_W-1:0] pp_lh;
  logic signed [EXT_W-1:0] pp_hl;
  logic signed [EXT_W-1:0] pp_hh;
  logic signed [EXT_W:0]   mid_sum;
  logic                    s2_valid;
  logic [EXT_W-1:0]        ll_q;
  logic signed [EXT_W:0]   mid_q;
  logic signed [EXT_W-1:0] hh_q;
  logic [PROD_W-1:0]       ll_ext;
  logic [PROD_W-1:0]       mid_ext;
  logic [PROD_W-1:0]       hh_ext;
  logic                    s3_valid;
  logic [PROD_W-1:0]       product_q;

  // Stage one builds the four cross products
  mul_partial_products i_pp (
    .CLK       (CLK),
    .nRST      (nRST),
    .in_valid  (start),
    .a_op      (multiplicand),
    .b_op      (multiplier_op),
    .is_signed (is_signed),
    .out_valid (s1_valid),
    .pp_ll     (pp_ll),
    .pp_lh     (pp_lh),
    .pp_hl     (pp_hl),
    .pp_hh     (pp_hh)
  );

  // Both middle terms share the 2^17 weight, so they add before alignment
  assign mid_sum = pp_lh + pp_hl;  // One extra bit absorbs the carry

  always_ff @(posedge CLK) begin
    if (s1_valid) begin
      ll_q  <= pp_ll;
      mid_q <= mid_sum;
      hh_q  <= pp_hh;
    end
  end

  // Everything is taken modulo 2^64 which gives the exact low product bits
  assign ll_ext  = {{(PROD_W-EXT_W){1'b0}}, ll_q};
  assign mid_ext = {{(PROD_W-EXT_W-1){mid_q[EXT_W]}}, mid_q} << HALF_W;
  assign hh_ext  = {{(PROD_W-EXT_W){hh_q[EXT_W-1]}}, hh_q} << EXT_W;  // High times high weighs 2^34

  always_ff @(posedge CLK) begin
    if (s2_valid) begin
      product_q <= ll_ext + mid_ext + hh_ext;
    end
  end

  // Each stage keeps its own valid so three operations can overlap
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      s2_valid <= 1'b0;
      s3_valid <= 1'b0;
    end else begin
      s2_valid <= s1_valid;
      s3_valid <= s2_valid;
    end
  end

  assign next_finished = s2_valid;  // One cycle ahead of the result
  assign finished      = s3_valid;
  assign product       = product_q;

endmodule

//--- verilog/mul_partial_products.sv
// First multiplier stage; operands must be stable on the in_valid edge and products appear one edge later
`timescale 1ns/1ps

module mul_partial_products (
  input  logic                               CLK,
  input  logic                               nRST,
  input  logic                               in_valid,
  input  logic [rv32m_pkg::WORD_W-1:0]       a_op,
  input  logic [rv32m_pkg::WORD_W-1:0]       b_op,
  input  rv32m_pkg::sign_type_t              is_signed,
  output logic                               out_valid,
  output logic [rv32m_pkg::EXT_W-1:0]        pp_ll,
  output logic signed [rv32m_pkg::EXT_W-1:0] pp_lh,
  output logic signed [rv32m_pkg::EXT_W-1:0] pp_hl,
  output logic signed [rv32m_pkg::EXT_W-1:0] pp_hh
);
  import rv32m_pkg::*;

  logic                     a_signed;
  logic                     b_signed;
  logic [EXT_W-1:0]         a_ext;
  logic [EXT_W-1:0]         b_ext;
  logic [HALF_W-1:0]        a_lo;
  logic [HALF_W-1:0]        b_lo;
  logic signed [HALF_W-1:0] a_hi;
  logic signed [HALF_W-1:0] b_hi;
  logic [EXT_W-1:0]         ll_next;
  logic signed [EXT_W-1:0]  lh_next;
  logic signed [EXT_W-1:0]  hl_next;
  logic signed [EXT_W-1:0]  hh_next;

  // The first operand is signed for SS and SU, the second for SS and US
  assign a_signed = (is_signed == SIGNED_SIGNED) || (is_signed == SIGNED_UNSIGNED);
  assign b_signed = (is_signed == SIGNED_SIGNED) || (is_signed == UNSIGNED_SIGNED);

  // Unsigned operands get a zero fill so every case becomes a signed 34-bit value
  assign a_ext = {{(EXT_W-WORD_W){a_signed & a_op[WORD_W-1]}}, a_op};
  assign b_ext = {{(EXT_W-WORD_W){b_signed & b_op[WORD_W-1]}}, b_op};

  // Split each operand into a plain low half and a two's complement high half
  assign a_lo = a_ext[HALF_W-1:0];
  assign b_lo = b_ext[HALF_W-1:0];
  assign a_hi = a_ext[EXT_W-1:HALF_W];
  assign b_hi = b_ext[EXT_W-1:HALF_W];

  // Low times low never goes negative so it stays unsigned
  assign ll_next = a_lo * b_lo;

  // A zero bit in front of each low half keeps it positive in a signed product
  assign lh_next = $signed({1'b0, a_lo}) * b_hi;
  assign hl_next = a_hi * $signed({1'b0, b_lo});

  // Largest magnitude is (-2^16)^2 which still fits in 34 signed bits
  assign hh_next = a_hi * b_hi;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;  // Valid walks alongside its products
    end
  end

  // Product registers only load when a real operation enters
  always_ff @(posedge CLK) begin
    if (in_valid) begin
      pp_ll <= ll_next;
      pp_lh <= lh_next;
      pp_hl <= hl_next;
      pp_hh <= hh_next;
    end
  end

endmodule

//--- verilog/rv32m_pkg.sv
// Shared RV32M multiply definitions; the width is fixed at 32 bits by the ISA and the pipeline depth is fixed at 3
package rv32m_pkg;

  // Architectural register width
  localparam int WORD_W = 32;

  // Full product width before the high or low word is chosen
  localparam int PROD_W = 2 * WORD_W;

  // Number of register stages between issue and finished
  localparam int MUL_LATENCY = 3;

  // Operands get two fill bits so a 33-bit signed value splits into two 17-bit halves
  localparam int EXT_W  = WORD_W + 2;
  localparam int HALF_W = EXT_W / 2;  // Low half is unsigned, high half carries the sign

  // Signedness of the two multiplier operands, first operand named first
  typedef enum logic [1:0] {
    SIGNED_SIGNED     = 2'b00,
    UNSIGNED_UNSIGNED = 2'b01,
    SIGNED_UNSIGNED   = 2'b10,  // Only seen at decode since the unit swaps it away
    UNSIGNED_SIGNED   = 2'b11
  } sign_type_t;

  // funct3 codes of the multiply group under the M extension opcode
  typedef enum logic [2:0] {
    FUNCT_MUL    = 3'b000,
    FUNCT_MULH   = 3'b001,
    FUNCT_MULHSU = 3'b010,
    FUNCT_MULHU  = 3'b011
  } m_funct_t;

endpackage
